//--- Makefile
# Verilator build and run for the branch predictor testbench

TOP       ?= bp_tb
SIM       ?= verilator
LOG       ?= sim.log
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(SIM), run $(TOP), write $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: TOP SIM LOG FLIST OBJ_DIR SIM_FLAGS"

test:
	$(SIM) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Failure reported in $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "No result line found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
source/bp_pkg.sv
source/bp_gshare.sv
source/bp_btb.sv
source/bp_ras.sv
source/bp_stats.sv
source/bp_top.sv
tb/bp_checker.sv
tb/bp_tb.sv

//--- source/bp_btb.sv
// Direct-mapped BTB; aliasing beyond TAG_BITS is not detected and targets are stored unchecked
`timescale 1ns/1ps

module bp_btb #(
    parameter int BTB_BITS = 6,
    parameter int TAG_BITS = 8
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [bp_pkg::ADDR_W-1:0]   lookup_pc_i,
    input  logic                        write_i,
    input  logic [bp_pkg::ADDR_W-1:0]   write_pc_i,
    input  logic [bp_pkg::ADDR_W-1:0]   write_target_i,
    output logic                        hit_o,
    output logic [bp_pkg::ADDR_W-1:0]   target_o
);

    localparam int BTB_SIZE = 1 << BTB_BITS;
    localparam int TAG_LSB  = bp_pkg::ALIGN_BITS + BTB_BITS;

    logic [BTB_SIZE-1:0]        valid_q;
    logic [TAG_BITS-1:0]        tag_mem    [BTB_SIZE];
    logic [bp_pkg::ADDR_W-1:0]  target_mem [BTB_SIZE];

    logic [BTB_BITS-1:0]        lookup_idx;
    logic [TAG_BITS-1:0]        lookup_tag;
    logic [BTB_BITS-1:0]        write_idx;
    logic [TAG_BITS-1:0]        write_tag;

    // ------------------------------
    // Address split
    // ------------------------------
    assign lookup_idx = lookup_pc_i[bp_pkg::ALIGN_BITS +: BTB_BITS];
    assign lookup_tag = lookup_pc_i[TAG_LSB +: TAG_BITS];
    assign write_idx  = write_pc_i[bp_pkg::ALIGN_BITS +: BTB_BITS];
    assign write_tag  = write_pc_i[TAG_LSB +: TAG_BITS];

    // Combinational lookup
    assign hit_o    = valid_q[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
    assign target_o = target_mem[lookup_idx];

    // ------------------------------
    // Update
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
        end else if (write_i) begin
            valid_q[write_idx] <= 1'b1;
        end
    end

    // A new tag simply replaces the old entry
    always_ff @(posedge clock) begin
        if (write_i) begin
            tag_mem[write_idx]    <= write_tag;
            target_mem[write_idx] <= write_target_i;
        end
    end

endmodule

//--- source/bp_gshare.sv
// Gshare direction predictor; PHT_BITS must be at least GHR_BITS and history is speculative at fetch
`timescale 1ns/1ps

module bp_gshare #(
    parameter int GHR_BITS = 8,
    parameter int PHT_BITS = 10
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        pred_valid_i,
    input  logic [bp_pkg::ADDR_W-1:0]   pred_pc_i,
    input  bp_pkg::bp_kind_e            pred_kind_i,
    input  logic                        train_valid_i,
    input  logic [bp_pkg::ADDR_W-1:0]   train_pc_i,
    input  bp_pkg::bp_kind_e            train_kind_i,
    input  logic                        train_taken_i,
    input  logic                        train_mispredict_i,
    input  logic [GHR_BITS-1:0]         train_ghr_i,
    output logic                        dir_taken_o,
    output logic [GHR_BITS-1:0]         ghr_o
);

    localparam int PHT_SIZE = 1 << PHT_BITS;

    if (PHT_BITS < GHR_BITS) begin : g_bad_size
        $error("bp_gshare needs PHT_BITS >= GHR_BITS");
    end

    logic [GHR_BITS-1:0]  ghr_q;
    bp_pkg::bp_counter_e  pht [PHT_SIZE];

    logic [PHT_BITS-1:0]  pred_idx;
    logic [PHT_BITS-1:0]  train_idx;
    logic [1:0]           pred_cnt;
    logic                 train_cond;
    logic                 recover;

    // ------------------------------
    // Index hash
    // ------------------------------
    // Word address xor zero-extended history
    assign pred_idx  = pred_pc_i[bp_pkg::ALIGN_BITS +: PHT_BITS] ^ PHT_BITS'(ghr_q);
    assign train_idx = train_pc_i[bp_pkg::ALIGN_BITS +: PHT_BITS] ^ PHT_BITS'(train_ghr_i);

    assign pred_cnt    = pht[pred_idx];
    assign dir_taken_o = pred_cnt[1];
    assign ghr_o       = ghr_q;

    assign train_cond = train_valid_i && (train_kind_i == bp_pkg::KIND_COND);
    assign recover    = train_cond && train_mispredict_i;

    // ------------------------------
    // Global history
    // ------------------------------
    // Recovery wins over the fetch shift in the same cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ghr_q <= '0;
        end else if (recover) begin
            ghr_q <= {train_ghr_i[GHR_BITS-2:0], train_taken_i};
        end else if (pred_valid_i && (pred_kind_i == bp_pkg::KIND_COND)) begin
            ghr_q <= {ghr_q[GHR_BITS-2:0], dir_taken_o};
        end
    end

    // ------------------------------
    // Pattern history table
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < PHT_SIZE; i++) begin
                pht[i] <= bp_pkg::STRONG_NOT_TAKEN;
            end
        end else if (train_cond) begin
            pht[train_idx] <= bp_pkg::next_counter(pht[train_idx], train_taken_i);
        end
    end

    // Index must be known whenever top level raises a strobe
    a_pred_idx_known: assert property (@(posedge clock) disable iff (reset)
        pred_valid_i |-> !$isunknown(pred_idx));

    a_train_idx_known: assert property (@(posedge clock) disable iff (reset)
        train_valid_i |-> !$isunknown(train_idx));

endmodule

//--- source/bp_pkg.sv
// Shared predictor types; address width fixed at 32 bits and fetch assumes 4-byte instructions
package bp_pkg;

    // ------------------------------
    // Address geometry
    // ------------------------------
    localparam int ADDR_W     = 32;
    localparam int ALIGN_BITS = 2;

    // Sequential fall-through step
    localparam logic [ADDR_W-1:0] INSN_STEP = ADDR_W'(4);

    // ------------------------------
    // Two-bit saturating counter
    // ------------------------------
    // Upper bit is the predicted direction
    typedef enum logic [1:0] {
        STRONG_NOT_TAKEN = 2'b00,
        WEAK_NOT_TAKEN   = 2'b01,
        WEAK_TAKEN       = 2'b10,
        STRONG_TAKEN     = 2'b11
    } bp_counter_e;

    // ------------------------------
    // Control transfer kind
    // ------------------------------
    typedef enum logic [2:0] {
        KIND_NONE   = 3'd0,
        KIND_COND   = 3'd1,
        KIND_JUMP   = 3'd2,
        KIND_CALL   = 3'd3,
        KIND_RETURN = 3'd4
    } bp_kind_e;

    // One saturating step toward the actual outcome
    function automatic bp_counter_e next_counter(input bp_counter_e cur, input logic taken);
        bp_counter_e nxt;
        case (cur)
            STRONG_NOT_TAKEN: nxt = taken ? WEAK_NOT_TAKEN : STRONG_NOT_TAKEN;
            WEAK_NOT_TAKEN:   nxt = taken ? WEAK_TAKEN : STRONG_NOT_TAKEN;
            WEAK_TAKEN:       nxt = taken ? STRONG_TAKEN : WEAK_NOT_TAKEN;
            STRONG_TAKEN:     nxt = taken ? STRONG_TAKEN : WEAK_TAKEN;
            default:          nxt = STRONG_NOT_TAKEN;
        endcase
        return nxt;
    endfunction

endpackage

//--- source/bp_ras.sv
// Return address stack; pushes past RAS_DEPTH are dropped and there is no mispredict repair
`timescale 1ns/1ps

module bp_ras #(
    parameter int RAS_DEPTH = 8
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        push_i,
    input  logic [bp_pkg::ADDR_W-1:0]   push_addr_i,
    input  logic                        pop_i,
    output logic [bp_pkg::ADDR_W-1:0]   top_o,
    output logic                        empty_o
);

    localparam int IDX_W = $clog2(RAS_DEPTH);
    localparam int PTR_W = IDX_W + 1;

    if (RAS_DEPTH != (1 << IDX_W)) begin : g_bad_depth
        $error("bp_ras needs a power of two RAS_DEPTH");
    end

    logic [bp_pkg::ADDR_W-1:0]  stack [RAS_DEPTH];
    logic [PTR_W-1:0]           ptr_q;
    logic                       do_pop;
    logic                       do_push;
    logic [IDX_W-1:0]           wr_slot;
    logic [IDX_W-1:0]           top_slot;

    // Pointer counts entries, top lives one below it
    assign top_slot = IDX_W'(ptr_q - 1'b1);
    assign empty_o  = (ptr_q == '0);
    assign top_o    = empty_o ? '0 : stack[top_slot];

    // Guards against underflow and overflow
    assign do_pop  = pop_i && !empty_o;
    assign do_push = push_i && ((ptr_q < PTR_W'(RAS_DEPTH)) || do_pop);

    // Push with pop overwrites the current top
    assign wr_slot = do_pop ? top_slot : IDX_W'(ptr_q);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ptr_q <= '0;
        end else if (do_push && !do_pop) begin
            ptr_q <= ptr_q + 1'b1;
        end else if (do_pop && !do_push) begin
            ptr_q <= ptr_q - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) begin
            stack[wr_slot] <= push_addr_i;
        end
    end

    a_ptr_in_range: assert property (@(posedge clock) disable iff (reset)
        ptr_q <= PTR_W'(RAS_DEPTH));

endmodule

//--- source/bp_stats.sv
// Retire statistics; counters wrap silently at STAT_W bits
`timescale 1ns/1ps

module bp_stats #(
    parameter int STAT_W = 32
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              train_valid_i,
    input  logic              train_mispredict_i,
    output logic [STAT_W-1:0] total_o,
    output logic [STAT_W-1:0] correct_o
);

    logic [STAT_W-1:0] total_q;
    logic [STAT_W-1:0] correct_q;

    // Every retiring strobe counts, only clean ones count as correct
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            total_q   <= '0;
            correct_q <= '0;
        end else if (train_valid_i) begin
            total_q <= total_q + 1'b1;
            if (!train_mispredict_i) begin
                correct_q <= correct_q + 1'b1;
            end
        end
    end

    assign total_o   = total_q;
    assign correct_o = correct_q;

    a_correct_bounded: assert property (@(posedge clock) disable iff (reset)
        correct_o <= total_o);

endmodule

//--- source/bp_top.sv
// Branch predictor top; prediction is combinational and training lands on the next clock edge
`timescale 1ns/1ps

module bp_top #(
    parameter int GHR_BITS  = 8,
    parameter int PHT_BITS  = 10,
    parameter int BTB_BITS  = 6,
    parameter int TAG_BITS  = 8,
    parameter int RAS_DEPTH = 8,
    parameter int STAT_W    = 32
) (
    input  logic                        clock,
    input  logic                        reset,
    // Fetch side
    input  logic                        pred_valid_i,
    input  logic [bp_pkg::ADDR_W-1:0]   pred_pc_i,
    input  bp_pkg::bp_kind_e            pred_kind_i,
    output logic                        pred_taken_o,
    output logic [bp_pkg::ADDR_W-1:0]   pred_target_o,
    output logic [GHR_BITS-1:0]         pred_ghr_o,
    // Retire side
    input  logic                        train_valid_i,
    input  logic [bp_pkg::ADDR_W-1:0]   train_pc_i,
    input  bp_pkg::bp_kind_e            train_kind_i,
    input  logic                        train_taken_i,
    input  logic [bp_pkg::ADDR_W-1:0]   train_target_i,
    input  logic                        train_mispredict_i,
    input  logic [GHR_BITS-1:0]         train_ghr_i,
    output logic [STAT_W-1:0]           stat_total_o,
    output logic [STAT_W-1:0]           stat_correct_o
);

    logic                       dir_taken;
    logic                       btb_hit;
    logic [bp_pkg::ADDR_W-1:0]  btb_target;
    logic                       btb_write;
    logic                       ras_push;
    logic                       ras_pop;
    logic [bp_pkg::ADDR_W-1:0]  ras_top;
    logic [bp_pkg::ADDR_W-1:0]  seq_pc;

    assign seq_pc = pred_pc_i + bp_pkg::INSN_STEP;

    // ------------------------------
    // Control derivation
    // ------------------------------
    assign ras_push  = pred_valid_i && (pred_kind_i == bp_pkg::KIND_CALL);
    assign ras_pop   = train_valid_i && (train_kind_i == bp_pkg::KIND_RETURN);
    assign btb_write = train_valid_i && train_taken_i &&
                       (train_kind_i inside {bp_pkg::KIND_COND, bp_pkg::KIND_JUMP,
                                             bp_pkg::KIND_CALL});

    bp_gshare #(
        .GHR_BITS (GHR_BITS),
        .PHT_BITS (PHT_BITS)
    ) gshare_i (
        .clock              (clock),
        .reset              (reset),
        .pred_valid_i       (pred_valid_i),
        .pred_pc_i          (pred_pc_i),
        .pred_kind_i        (pred_kind_i),
        .train_valid_i      (train_valid_i),
        .train_pc_i         (train_pc_i),
        .train_kind_i       (train_kind_i),
        .train_taken_i      (train_taken_i),
        .train_mispredict_i (train_mispredict_i),
        .train_ghr_i        (train_ghr_i),
        .dir_taken_o        (dir_taken),
        .ghr_o              (pred_ghr_o)
    );

    bp_btb #(
        .BTB_BITS (BTB_BITS),
        .TAG_BITS (TAG_BITS)
    ) btb_i (
        .clock          (clock),
        .reset          (reset),
        .lookup_pc_i    (pred_pc_i),
        .write_i        (btb_write),
        .write_pc_i     (train_pc_i),
        .write_target_i (train_target_i),
        .hit_o          (btb_hit),
        .target_o       (btb_target)
    );

    // Return targets come from the stack top, zero when empty
    bp_ras #(
        .RAS_DEPTH (RAS_DEPTH)
    ) ras_i (
        .clock       (clock),
        .reset       (reset),
        .push_i      (ras_push),
        .push_addr_i (seq_pc),
        .pop_i       (ras_pop),
        .top_o       (ras_top),
        .empty_o     ()
    );

    bp_stats #(
        .STAT_W (STAT_W)
    ) stats_i (
        .clock              (clock),
        .reset              (reset),
        .train_valid_i      (train_valid_i),
        .train_mispredict_i (train_mispredict_i),
        .total_o            (stat_total_o),
        .correct_o          (stat_correct_o)
    );

    // ------------------------------
    // Final prediction select
    // ------------------------------
    always_comb begin
        pred_taken_o  = 1'b0;
        pred_target_o = seq_pc;
        case (pred_kind_i)
            bp_pkg::KIND_RETURN: begin
                pred_taken_o  = 1'b1;
                pred_target_o = ras_top;
            end
            bp_pkg::KIND_JUMP, bp_pkg::KIND_CALL: begin
                pred_taken_o = 1'b1;
                if (btb_hit) begin
                    pred_target_o = btb_target;
                end
            end
            bp_pkg::KIND_COND: begin
                pred_taken_o = dir_taken;
                // BTB target only when gshare says taken
                if (dir_taken && btb_hit) begin
                    pred_target_o = btb_target;
                end
            end
            default: begin
                pred_taken_o = 1'b0;
            end
        endcase
    end

endmodule

//--- tb/bp_checker.sv
// Compares bp_top outputs with expected values mid-cycle; expected counts are only 8 bits wide
`timescale 1ns/1ps

module bp_checker #(
    parameter int GHR_BITS = 8,
    parameter int STAT_W   = 32
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        check_en_i,
    input  logic                        flush_i,
    input  logic [7:0]                  test_num_i,
    input  logic                        exp_taken_i,
    input  logic [31:0]                 exp_target_i,
    input  logic [7:0]                  exp_ghr_i,
    input  logic [7:0]                  exp_total_i,
    input  logic [7:0]                  exp_correct_i,
    input  logic                        pred_taken_i,
    input  logic [bp_pkg::ADDR_W-1:0]   pred_target_i,
    input  logic [GHR_BITS-1:0]         pred_ghr_i,
    input  logic [STAT_W-1:0]           stat_total_i,
    input  logic [STAT_W-1:0]           stat_correct_i,
    output int                          error_count_o,
    output int                          check_count_o,
    output int                          test_count_o
);

    int         errors;
    int         checks;
    int         tests;
    int         test_errors;
    int         test_cycles;
    logic [7:0] cur_test;
    logic       test_open;

    assign error_count_o = errors;
    assign check_count_o = checks;
    assign test_count_o  = tests;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("Fail %s expected %h actual %h (test %0d, %0t)",
                     name, expected, actual, cur_test, $time);
        end
    endtask

    task automatic report_test();
        if (test_errors == 0) begin
            $display("Test %0d passed after %0d cycles", cur_test, test_cycles);
        end else begin
            $display("Test %0d failed with %0d errors in %0d cycles",
                     cur_test, test_errors, test_cycles);
        end
        tests++;
        test_open = 1'b0;
    endtask

    // ------------------------------
    // Mid-cycle sampling
    // ------------------------------
    // Inputs change on the rising edge, so outputs are settled here
    always @(negedge clock or posedge reset) begin
        if (reset) begin
            errors      = 0;
            checks      = 0;
            tests       = 0;
            test_errors = 0;
            test_cycles = 0;
            cur_test    = '0;
            test_open   = 1'b0;
        end else if (check_en_i) begin
            if (test_open && (test_num_i != cur_test)) begin
                report_test();
            end
            if (!test_open) begin
                cur_test    = test_num_i;
                test_errors = 0;
                test_cycles = 0;
                test_open   = 1'b1;
            end
            test_cycles++;
            compare_value("pred_taken_o", 32'(exp_taken_i), 32'(pred_taken_i));
            compare_value("pred_target_o", exp_target_i, 32'(pred_target_i));
            compare_value("pred_ghr_o", 32'(exp_ghr_i), 32'(pred_ghr_i));
            compare_value("stat_total_o", 32'(exp_total_i), 32'(stat_total_i));
            compare_value("stat_correct_o", 32'(exp_correct_i), 32'(stat_correct_i));
        end else if (flush_i && test_open) begin
            // Last test has no successor to close it
            report_test();
        end
    end

endmodule

//--- tb/bp_stimulus.mem
// test_fetch(valid,kind)_fetchpc_train(flags v/t/m,kind)_trainpc_traintarget_trainghr
// _exptaken_exptarget_expghr_exptotal_expcorrect, one line per cycle
01_11_00001000_00_00000000_00000000_00_0_00001004_00_00_00
01_10_00002000_00_00000000_00000000_00_0_00002004_00_00_00
02_00_00000000_61_00000100_00000400_00_0_00000004_00_00_00
02_11_00000100_61_00000100_00000400_00_0_00000104_00_01_01
02_11_00000100_00_00000000_00000000_00_1_00000400_00_02_02
02_00_00000000_51_00000100_00000104_00_0_00000004_01_02_02
02_11_00000100_41_00000100_00000104_00_0_00000104_00_03_02
02_11_00000100_41_00000100_00000104_00_0_00000104_00_04_03
02_11_00000100_00_00000000_00000000_00_0_00000104_00_05_04
03_00_00000000_71_00000204_00000600_5A_0_00000004_00_05_04
03_11_00000300_00_00000000_00000000_00_0_00000304_B5_06_04
03_10_00000310_61_00000100_00000400_6A_0_00000314_6A_06_04
03_12_00000320_61_00000100_00000400_6A_1_00000324_6A_07_05
03_14_00000330_00_00000000_00000000_00_1_00000000_6A_08_06
03_11_00000100_00_00000000_00000000_00_1_00000400_6A_08_06
03_11_00000300_51_00000800_00000804_00_0_00000304_D5_08_06
03_10_00000340_00_00000000_00000000_00_0_00000344_00_09_06
04_13_00001000_00_00000000_00000000_00_1_00001004_00_09_06
04_13_00002040_00_00000000_00000000_00_1_00002044_00_09_06
04_14_00003000_64_00003000_00002044_00_1_00002044_00_09_06
04_14_00003100_64_00003100_00001004_00_1_00001004_00_0A_07
04_14_00003200_64_00003200_00000000_00_1_00000000_00_0B_08
04_13_00001000_00_00000000_00000000_00_1_00001004_00_0C_09
04_14_00003200_00_00000000_00000000_00_1_00001004_00_0C_09
05_12_00000204_72_00000104_00000A00_00_1_00000600_00_0C_09
05_12_00000204_00_00000000_00000000_00_1_00000208_00_0D_09
05_12_00000104_63_00000204_00000C00_00_1_00000A00_00_0D_09
05_12_00000104_00_00000000_00000000_00_1_00000108_00_0E_0A
05_12_00000204_00_00000000_00000000_00_1_00000C00_00_0E_0A
06_00_00000000_50_00000500_00000504_00_0_00000004_00_0E_0A
06_00_00000000_62_00000508_00000700_00_0_00000004_00_0F_0A
06_00_00000000_51_00000800_00000804_00_0_00000004_00_10_0B
06_00_00000000_00_00000000_00000000_00_0_00000004_00_11_0B

//--- tb/bp_tb.sv
// Testbench for bp_top at default parameters; expects tb/bp_stimulus.mem relative to the run directory
`timescale 1ns/1ps

module bp_tb;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_LINES  = 64;
    localparam int LINE_W     = 188;
    localparam int GHR_BITS   = 8;
    localparam int STAT_W     = 32;

    logic                       clock;
    logic                       reset;

    // DUT inputs
    logic                       pred_valid;
    logic [bp_pkg::ADDR_W-1:0]  pred_pc;
    bp_pkg::bp_kind_e           pred_kind;
    logic                       train_valid;
    logic [bp_pkg::ADDR_W-1:0]  train_pc;
    bp_pkg::bp_kind_e           train_kind;
    logic                       train_taken;
    logic [bp_pkg::ADDR_W-1:0]  train_target;
    logic                       train_mispredict;
    logic [GHR_BITS-1:0]        train_ghr;

    // DUT outputs
    logic                       pred_taken;
    logic [bp_pkg::ADDR_W-1:0]  pred_target;
    logic [GHR_BITS-1:0]        pred_ghr;
    logic [STAT_W-1:0]          stat_total;
    logic [STAT_W-1:0]          stat_correct;

    // Expected values for the checker
    logic                       check_en;
    logic                       flush;
    logic [7:0]                 exp_test;
    logic                       exp_taken;
    logic [31:0]                exp_target;
    logic [7:0]                 exp_ghr;
    logic [7:0]                 exp_total;
    logic [7:0]                 exp_correct;

    int                         error_count;
    int                         check_count;
    int                         test_count;
    int                         n_lines;
    logic                       lines_ready;

    logic [LINE_W-1:0]          stim_mem [MAX_LINES];

    bp_top #(
        .GHR_BITS (GHR_BITS),
        .STAT_W   (STAT_W)
    ) dut_i (
        .clock              (clock),
        .reset              (reset),
        .pred_valid_i       (pred_valid),
        .pred_pc_i          (pred_pc),
        .pred_kind_i        (pred_kind),
        .pred_taken_o       (pred_taken),
        .pred_target_o      (pred_target),
        .pred_ghr_o         (pred_ghr),
        .train_valid_i      (train_valid),
        .train_pc_i         (train_pc),
        .train_kind_i       (train_kind),
        .train_taken_i      (train_taken),
        .train_target_i     (train_target),
        .train_mispredict_i (train_mispredict),
        .train_ghr_i        (train_ghr),
        .stat_total_o       (stat_total),
        .stat_correct_o     (stat_correct)
    );

    bp_checker #(
        .GHR_BITS (GHR_BITS),
        .STAT_W   (STAT_W)
    ) check_i (
        .clock          (clock),
        .reset          (reset),
        .check_en_i     (check_en),
        .flush_i        (flush),
        .test_num_i     (exp_test),
        .exp_taken_i    (exp_taken),
        .exp_target_i   (exp_target),
        .exp_ghr_i      (exp_ghr),
        .exp_total_i    (exp_total),
        .exp_correct_i  (exp_correct),
        .pred_taken_i   (pred_taken),
        .pred_target_i  (pred_target),
        .pred_ghr_i     (pred_ghr),
        .stat_total_i   (stat_total),
        .stat_correct_i (stat_correct),
        .error_count_o  (error_count),
        .check_count_o  (check_count),
        .test_count_o   (test_count)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clock = ~clock;
        end
    end

    // ------------------------------
    // Line layout from the msb down
    // ------------------------------
    // test, fetch valid/kind, fetch pc, train flags/kind, train pc, train target,
    // train ghr, expected taken, target, ghr, total, correct
    task automatic apply_line(input logic [LINE_W-1:0] line);
        exp_test         <= line[187:180];
        pred_valid       <= line[176];
        pred_kind        <= bp_pkg::bp_kind_e'(line[174:172]);
        pred_pc          <= line[171:140];
        train_valid      <= line[138];
        train_taken      <= line[137];
        train_mispredict <= line[136];
        train_kind       <= bp_pkg::bp_kind_e'(line[134:132]);
        train_pc         <= line[131:100];
        train_target     <= line[99:68];
        train_ghr        <= line[67:60];
        exp_taken        <= line[56];
        exp_target       <= line[55:24];
        exp_ghr          <= line[23:16];
        exp_total        <= line[15:8];
        exp_correct      <= line[7:0];
        check_en         <= 1'b1;
    endtask

    task automatic drive_idle();
        pred_valid       <= 1'b0;
        pred_kind        <= bp_pkg::KIND_NONE;
        pred_pc          <= '0;
        train_valid      <= 1'b0;
        train_taken      <= 1'b0;
        train_mispredict <= 1'b0;
        train_kind       <= bp_pkg::KIND_NONE;
        check_en         <= 1'b0;
    endtask

    initial begin
        reset            = 1'b1;
        pred_valid       = 1'b0;
        pred_pc          = '0;
        pred_kind        = bp_pkg::KIND_NONE;
        train_valid      = 1'b0;
        train_pc         = '0;
        train_kind       = bp_pkg::KIND_NONE;
        train_taken      = 1'b0;
        train_target     = '0;
        train_mispredict = 1'b0;
        train_ghr        = '0;
        check_en         = 1'b0;
        flush            = 1'b0;
        exp_test         = '0;
        exp_taken        = 1'b0;
        exp_target       = '0;
        exp_ghr          = '0;
        exp_total        = '0;
        exp_correct      = '0;
        lines_ready      = 1'b0;
        n_lines          = 0;

        $readmemh("tb/bp_stimulus.mem", stim_mem);
        // Test number zero or unread entry ends the list
        while ((n_lines < MAX_LINES) && !$isunknown(stim_mem[n_lines])
               && (stim_mem[n_lines][187:180] != 8'h00)) begin
            n_lines++;
        end
        lines_ready = 1'b1;
        if (n_lines == 0) begin
            $display("Stimulus file is missing or empty, nothing was tested");
        end

        repeat (2) @(posedge clock);
        reset <= 1'b0;

        for (int i = 0; i < n_lines; i++) begin
            @(posedge clock);
            apply_line(stim_mem[i]);
        end

        @(posedge clock);
        drive_idle();
        flush <= 1'b1;
        @(posedge clock);
        flush <= 1'b0;
        @(posedge clock);

        $display("Tests: %0d  checks: %0d  errors: %0d", test_count, check_count, error_count);
        if ((error_count == 0) && (n_lines > 0)) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the stimulus length
    initial begin
        wait (lines_ready);
        #(CLK_PERIOD * (n_lines + 20));
        $display("Timeout: run did not end within %0d clock cycles", n_lines + 20);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
